//--- hdl/mpeg_config.svh
`ifndef MPEG_CONFIG_SVH
`define MPEG_CONFIG_SVH

// Video event FIFO holds 2**3 entries
`define MPEG_FIFO_DEPTH_LOG2 3

// Host register port
`define MPEG_REG_ADDR_W 4
`define MPEG_REG_DATA_W 16

// System clock reference from the pack header
`define MPEG_SCR_W 33

// GOP timecode from the top 25 bits of the four GOP payload bytes
`define MPEG_TIMECODE_W 25

// Picture temporal reference
`define MPEG_TMPREF_W 10

`endif

//--- hdl/mpeg_stream_pkg.sv
package mpeg_stream_pkg;

    // Code byte that follows the 00 00 01 prefix
    typedef enum logic [7:0] {
        PICTURE  = 8'h00,
        SEQUENCE = 8'hB3,
        GOP      = 8'hB8,
        PACK     = 8'hBA
    } start_code_e;

    // Video parser states for start code tracking and header payload
    typedef enum logic [3:0] {
        IDLE,
        ZERO1,
        ZERO2,
        MATCH,
        SEQ0,
        GOP0, GOP1, GOP2, GOP3,
        PIC0, PIC1, PIC2, PIC3
    } video_state_e;

    // Audio parser states for the pack header only
    typedef enum logic [3:0] {
        A_IDLE,
        A_ZERO1,
        A_ZERO2,
        A_MATCH,
        PACK0, PACK1, PACK2, PACK3, PACK4
    } audio_state_e;

    typedef enum logic [1:0] {
        EV_SEQ,
        EV_GOP,
        EV_PIC
    } video_event_e;

endpackage

//--- hdl/mpeg_regs_pkg.sv
package mpeg_regs_pkg;

    // Word addresses on the host register port
    typedef enum logic [3:0] {
        IER         = 4'd0,
        ISR         = 4'd1,
        TIMECODE_HI = 4'd2,
        TIMECODE_LO = 4'd3,
        TMPREF      = 4'd4,
        SCR_HI      = 4'd5,
        SCR_LO      = 4'd6,
        PACK_COUNT  = 4'd7
    } reg_addr_e;

    // Flag positions in IER and ISR
    typedef enum logic [1:0] {
        ISR_SEQ  = 2'd0,
        ISR_GOP  = 2'd1,
        ISR_PIC  = 2'd2,
        ISR_PACK = 2'd3
    } isr_bit_e;

endpackage

//--- hdl/video_header_parser.sv
`timescale 1ns/1ps
`include "mpeg_config.svh"

module video_header_parser (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [7:0]                    in_data,
    input  logic                          in_audio,
    input  logic                          in_valid,
    input  logic                          in_ready,
    output logic                          ev_write,
    output mpeg_stream_pkg::video_event_e ev_kind,
    output logic [`MPEG_TIMECODE_W-1:0]   ev_timecode,
    output logic [`MPEG_TMPREF_W-1:0]     ev_tmpref
);

    mpeg_stream_pkg::video_state_e state;
    logic accept;

    // Only video tagged bytes advance this parser
    assign accept = in_valid && in_ready && !in_audio;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= mpeg_stream_pkg::IDLE;
            ev_write <= 1'b0;
        end else begin
            ev_write <= 1'b0;
            if (accept) begin
                state <= mpeg_stream_pkg::IDLE;
                case (state)
                    mpeg_stream_pkg::IDLE: begin
                        if (in_data == 8'h00)
                            state <= mpeg_stream_pkg::ZERO1;
                    end
                    mpeg_stream_pkg::ZERO1: begin
                        if (in_data == 8'h00)
                            state <= mpeg_stream_pkg::ZERO2;
                    end
                    mpeg_stream_pkg::ZERO2: begin
                        // Extra zero bytes keep the prefix alive
                        if (in_data == 8'h00)
                            state <= mpeg_stream_pkg::ZERO2;
                        else if (in_data == 8'h01)
                            state <= mpeg_stream_pkg::MATCH;
                    end
                    mpeg_stream_pkg::MATCH: begin
                        case (in_data)
                            mpeg_stream_pkg::SEQUENCE: state <= mpeg_stream_pkg::SEQ0;
                            mpeg_stream_pkg::GOP:      state <= mpeg_stream_pkg::GOP0;
                            mpeg_stream_pkg::PICTURE:  state <= mpeg_stream_pkg::PIC0;
                            default:                   state <= mpeg_stream_pkg::IDLE;
                        endcase
                    end
                    mpeg_stream_pkg::SEQ0: begin
                        ev_write <= 1'b1;
                        ev_kind  <= mpeg_stream_pkg::EV_SEQ;
                    end
                    // Timecode in stream order, MSB first
                    mpeg_stream_pkg::GOP0: begin
                        ev_timecode[24:17] <= in_data;
                        state              <= mpeg_stream_pkg::GOP1;
                    end
                    mpeg_stream_pkg::GOP1: begin
                        ev_timecode[16:9] <= in_data;
                        state             <= mpeg_stream_pkg::GOP2;
                    end
                    mpeg_stream_pkg::GOP2: begin
                        ev_timecode[8:1] <= in_data;
                        state            <= mpeg_stream_pkg::GOP3;
                    end
                    mpeg_stream_pkg::GOP3: begin
                        ev_timecode[0] <= in_data[7];
                        ev_write       <= 1'b1;
                        ev_kind        <= mpeg_stream_pkg::EV_GOP;
                    end
                    mpeg_stream_pkg::PIC0: begin
                        ev_tmpref[9:2] <= in_data;
                        state          <= mpeg_stream_pkg::PIC1;
                    end
                    mpeg_stream_pkg::PIC1: begin
                        ev_tmpref[1:0] <= in_data[7:6];
                        state          <= mpeg_stream_pkg::PIC2;
                    end
                    // Picture type and VBV delay are skipped
                    mpeg_stream_pkg::PIC2: begin
                        state <= mpeg_stream_pkg::PIC3;
                    end
                    mpeg_stream_pkg::PIC3: begin
                        ev_write <= 1'b1;
                        ev_kind  <= mpeg_stream_pkg::EV_PIC;
                    end
                    default: state <= mpeg_stream_pkg::IDLE;
                endcase
            end
        end
    end

    // Each header needs at least two accepted bytes, so the FIFO is never flooded
    assert property (@(posedge clk) disable iff (reset) ev_write |=> !ev_write);

endmodule

//--- hdl/audio_pack_parser.sv
`timescale 1ns/1ps
`include "mpeg_config.svh"

module audio_pack_parser (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [7:0]             in_data,
    input  logic                   in_audio,
    input  logic                   in_valid,
    input  logic                   in_ready,
    output logic                   scr_valid,
    output logic [`MPEG_SCR_W-1:0] scr
);

    mpeg_stream_pkg::audio_state_e state;
    logic accept;

    assign accept = in_valid && in_ready && in_audio;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= mpeg_stream_pkg::A_IDLE;
            scr_valid <= 1'b0;
        end else begin
            scr_valid <= 1'b0;
            if (accept) begin
                state <= mpeg_stream_pkg::A_IDLE;
                case (state)
                    mpeg_stream_pkg::A_IDLE: begin
                        if (in_data == 8'h00)
                            state <= mpeg_stream_pkg::A_ZERO1;
                    end
                    mpeg_stream_pkg::A_ZERO1: begin
                        if (in_data == 8'h00)
                            state <= mpeg_stream_pkg::A_ZERO2;
                    end
                    mpeg_stream_pkg::A_ZERO2: begin
                        if (in_data == 8'h00)
                            state <= mpeg_stream_pkg::A_ZERO2;
                        else if (in_data == 8'h01)
                            state <= mpeg_stream_pkg::A_MATCH;
                    end
                    mpeg_stream_pkg::A_MATCH: begin
                        if (in_data == mpeg_stream_pkg::PACK)
                            state <= mpeg_stream_pkg::PACK0;
                    end
                    // Marker bits are dropped while the SCR is assembled
                    mpeg_stream_pkg::PACK0: begin
                        scr[32:30] <= in_data[3:1];
                        state      <= mpeg_stream_pkg::PACK1;
                    end
                    mpeg_stream_pkg::PACK1: begin
                        scr[29:22] <= in_data;
                        state      <= mpeg_stream_pkg::PACK2;
                    end
                    mpeg_stream_pkg::PACK2: begin
                        scr[21:15] <= in_data[7:1];
                        state      <= mpeg_stream_pkg::PACK3;
                    end
                    mpeg_stream_pkg::PACK3: begin
                        scr[14:7] <= in_data;
                        state     <= mpeg_stream_pkg::PACK4;
                    end
                    mpeg_stream_pkg::PACK4: begin
                        scr[6:0]  <= in_data[7:1];
                        scr_valid <= 1'b1;
                    end
                    default: state <= mpeg_stream_pkg::A_IDLE;
                endcase
            end
        end
    end

endmodule

//--- hdl/video_event_fifo.sv
`timescale 1ns/1ps
`include "mpeg_config.svh"

module video_event_fifo (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          write,
    input  mpeg_stream_pkg::video_event_e in_kind,
    input  logic [`MPEG_TIMECODE_W-1:0]   in_timecode,
    input  logic [`MPEG_TMPREF_W-1:0]     in_tmpref,
    input  logic                          pop,
    output mpeg_stream_pkg::video_event_e out_kind,
    output logic [`MPEG_TIMECODE_W-1:0]   out_timecode,
    output logic [`MPEG_TMPREF_W-1:0]     out_tmpref,
    output logic                          out_valid,
    output logic                          almost_full
);

    localparam int AW    = `MPEG_FIFO_DEPTH_LOG2;
    localparam int DEPTH = 1 << AW;
    localparam int W     = 2 + `MPEG_TIMECODE_W + `MPEG_TMPREF_W;

    logic [W-1:0]  mem [DEPTH];
    logic [W-1:0]  rd_word;
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] rd_ptr_next;
    logic [AW:0]   count;
    // Next read slot written this cycle, so rd_word still holds old data
    logic          fresh_d;
    logic          fresh_q;

    assign rd_ptr_next = pop ? rd_ptr + 1'b1 : rd_ptr;
    assign fresh_d     = write && (wr_ptr == rd_ptr_next);

    assign out_valid   = (count != '0) && !fresh_q;
    assign almost_full = count >= (AW + 1)'(DEPTH - 1);

    assign out_tmpref   = rd_word[`MPEG_TMPREF_W-1:0];
    assign out_timecode = rd_word[`MPEG_TMPREF_W +: `MPEG_TIMECODE_W];
    assign out_kind     = mpeg_stream_pkg::video_event_e'(rd_word[W-1 -: 2]);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            fresh_q <= 1'b0;
        end else begin
            if (write)
                wr_ptr <= wr_ptr + 1'b1;
            rd_ptr  <= rd_ptr_next;
            fresh_q <= fresh_d;
            if (write && !pop)
                count <= count + 1'b1;
            else if (pop && !write)
                count <= count - 1'b1;
        end
    end

    // Storage and registered read port
    always_ff @(posedge clk) begin
        if (write)
            mem[wr_ptr] <= {in_kind, in_timecode, in_tmpref};
        rd_word <= mem[rd_ptr_next];
    end

    assert property (@(posedge clk) disable iff (reset) !(write && count == DEPTH));
    assert property (@(posedge clk) disable iff (reset) pop |-> out_valid);

endmodule

//--- hdl/mpeg_host_regs.sv
`timescale 1ns/1ps
`include "mpeg_config.svh"

module mpeg_host_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ev_write,
    input  mpeg_stream_pkg::video_event_e ev_kind,
    input  logic [`MPEG_TIMECODE_W-1:0]   ev_timecode,
    input  logic [`MPEG_TMPREF_W-1:0]     ev_tmpref,
    input  logic                          scr_valid,
    input  logic [`MPEG_SCR_W-1:0]        scr,
    input  logic                          vsync,
    input  logic [`MPEG_REG_ADDR_W-1:0]   reg_addr,
    input  logic                          reg_write,
    input  logic                          reg_read,
    input  logic [`MPEG_REG_DATA_W-1:0]   reg_wdata,
    output logic [`MPEG_REG_DATA_W-1:0]   reg_rdata,
    output logic                          irq,
    output logic                          in_ready
);

    mpeg_stream_pkg::video_event_e fifo_kind;
    logic [`MPEG_TIMECODE_W-1:0] fifo_timecode;
    logic [`MPEG_TMPREF_W-1:0]   fifo_tmpref;
    logic                        fifo_valid;
    logic                        fifo_almost_full;

    logic [`MPEG_TIMECODE_W-1:0] timecode;
    logic [`MPEG_TMPREF_W-1:0]   tmpref;
    logic [`MPEG_SCR_W-1:0]      scr_reg;
    logic [15:0]                 pack_count;
    logic [3:0]                  ier;
    logic [3:0]                  isr;
    logic [3:0]                  isr_set;
    logic                        isr_clear;
    logic                        vsync_q;
    logic                        vsync_rise;
    logic                        phase;
    logic                        release_ev;

    video_event_fifo u_event_fifo (
        .clk          (clk),
        .reset        (reset),
        .write        (ev_write),
        .in_kind      (ev_kind),
        .in_timecode  (ev_timecode),
        .in_tmpref    (ev_tmpref),
        .pop          (release_ev),
        .out_kind     (fifo_kind),
        .out_timecode (fifo_timecode),
        .out_tmpref   (fifo_tmpref),
        .out_valid    (fifo_valid),
        .almost_full  (fifo_almost_full)
    );

    assign in_ready   = !fifo_almost_full;
    assign vsync_rise = vsync && !vsync_q;
    // One event per pair of vsync rising edges
    assign release_ev = vsync_rise && phase && fifo_valid;
    assign isr_clear  = reg_read && (reg_addr == mpeg_regs_pkg::ISR);

    always_comb begin
        isr_set = '0;
        if (release_ev) begin
            case (fifo_kind)
                mpeg_stream_pkg::EV_SEQ: isr_set[mpeg_regs_pkg::ISR_SEQ] = 1'b1;
                mpeg_stream_pkg::EV_GOP: isr_set[mpeg_regs_pkg::ISR_GOP] = 1'b1;
                mpeg_stream_pkg::EV_PIC: isr_set[mpeg_regs_pkg::ISR_PIC] = 1'b1;
                default: ;
            endcase
        end
        if (scr_valid)
            isr_set[mpeg_regs_pkg::ISR_PACK] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vsync_q    <= 1'b0;
            phase      <= 1'b0;
            ier        <= '0;
            isr        <= '0;
            irq        <= 1'b0;
            timecode   <= '0;
            tmpref     <= '0;
            scr_reg    <= '0;
            pack_count <= '0;
        end else begin
            vsync_q <= vsync;
            if (vsync_rise)
                phase <= !phase;
            if (reg_write && reg_addr == mpeg_regs_pkg::IER)
                ier <= reg_wdata[3:0];
            // New flags win over the read clear
            isr <= (isr_clear ? 4'b0 : isr) | isr_set;
            irq <= |(isr & ier);
            if (release_ev && fifo_kind == mpeg_stream_pkg::EV_GOP)
                timecode <= fifo_timecode;
            if (release_ev && fifo_kind == mpeg_stream_pkg::EV_PIC)
                tmpref <= fifo_tmpref;
            if (scr_valid) begin
                scr_reg    <= scr;
                pack_count <= pack_count + 1'b1;
            end
        end
    end

    // Host sees the SCR in 45 kHz units as bits 32 to 1
    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            mpeg_regs_pkg::IER:         reg_rdata[3:0] = ier;
            mpeg_regs_pkg::ISR:         reg_rdata[3:0] = isr;
            mpeg_regs_pkg::TIMECODE_HI: reg_rdata[8:0] = timecode[24:16];
            mpeg_regs_pkg::TIMECODE_LO: reg_rdata      = timecode[15:0];
            mpeg_regs_pkg::TMPREF:      reg_rdata[9:0] = tmpref;
            mpeg_regs_pkg::SCR_HI:      reg_rdata      = scr_reg[32:17];
            mpeg_regs_pkg::SCR_LO:      reg_rdata      = scr_reg[16:1];
            mpeg_regs_pkg::PACK_COUNT:  reg_rdata      = pack_count;
            default: ;
        endcase
    end

    // A cleared enable mask silences the interrupt one cycle later
    assert property (@(posedge clk) disable iff (reset) (ier == '0) |=> !irq);

endmodule

//--- hdl/mpeg_decoder_top.sv
`timescale 1ns/1ps
`include "mpeg_config.svh"

module mpeg_decoder_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [7:0]                  in_data,
    input  logic                        in_audio,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic                        vsync,
    input  logic [`MPEG_REG_ADDR_W-1:0] reg_addr,
    input  logic                        reg_write,
    input  logic                        reg_read,
    input  logic [`MPEG_REG_DATA_W-1:0] reg_wdata,
    output logic [`MPEG_REG_DATA_W-1:0] reg_rdata,
    output logic                        irq
);

    logic                          ev_write;
    mpeg_stream_pkg::video_event_e ev_kind;
    logic [`MPEG_TIMECODE_W-1:0]   ev_timecode;
    logic [`MPEG_TMPREF_W-1:0]     ev_tmpref;
    logic                          scr_valid;
    logic [`MPEG_SCR_W-1:0]        scr;

    video_header_parser u_video_parser (
        .clk         (clk),
        .reset       (reset),
        .in_data     (in_data),
        .in_audio    (in_audio),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .ev_write    (ev_write),
        .ev_kind     (ev_kind),
        .ev_timecode (ev_timecode),
        .ev_tmpref   (ev_tmpref)
    );

    audio_pack_parser u_audio_parser (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .in_audio  (in_audio),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .scr_valid (scr_valid),
        .scr       (scr)
    );

    mpeg_host_regs u_host_regs (
        .clk         (clk),
        .reset       (reset),
        .ev_write    (ev_write),
        .ev_kind     (ev_kind),
        .ev_timecode (ev_timecode),
        .ev_tmpref   (ev_tmpref),
        .scr_valid   (scr_valid),
        .scr         (scr),
        .vsync       (vsync),
        .reg_addr    (reg_addr),
        .reg_write   (reg_write),
        .reg_read    (reg_read),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .irq         (irq),
        .in_ready    (in_ready)
    );

endmodule

//--- tb/tb_mpeg_decoder.sv
`timescale 1ns/1ps

module tb_mpeg_decoder;

    logic        clk;
    logic        reset;
    logic [7:0]  in_data;
    logic        in_audio;
    logic        in_valid;
    logic        in_ready;
    logic        vsync;
    logic [3:0]  reg_addr;
    logic        reg_write;
    logic        reg_read;
    logic [15:0] reg_wdata;
    logic [15:0] reg_rdata;
    logic        irq;

    int seed = 9434;
    int errors = 0;
    int cycles = 0;
    int limit = 32'h7fffffff;
    int sent = 0;
    bit stream_done = 0;
    bit hold_vsync = 1;
    bit ready_dropped = 0;
    bit tb_phase = 0;

    // Byte stream in transfer order
    logic [7:0]  data_q[$];
    bit          audio_q[$];
    // Expected video events and the SCR of every pack in order
    int          ev_kind_q[$];
    logic [24:0] ev_tc_q[$];
    logic [9:0]  ev_tr_q[$];
    logic [32:0] scr_hist[$];

    // Model state
    int          vstate = 0;
    int          astate = 0;
    logic [31:0] vword = '0;
    logic [39:0] aword = '0;

    mpeg_decoder_top i_mpeg_decoder_top (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .in_audio  (in_audio),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .vsync     (vsync),
        .reg_addr  (reg_addr),
        .reg_write (reg_write),
        .reg_read  (reg_read),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .irq       (irq)
    );

    initial begin
        clk = 0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: the run went past its cycle limit of %0d", limit);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic int rnd(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    task automatic report(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // Start code prefix shared by both parsers; returns the next state
    function automatic int prefix_step(input int st, input logic [7:0] b);
        case (st)
            0: return (b == 8'h00) ? 1 : 0;
            1: return (b == 8'h00) ? 2 : 0;
            2: return (b == 8'h00) ? 2 : ((b == 8'h01) ? 3 : 0);
            default: return 0;
        endcase
    endfunction

    task automatic model_video(input logic [7:0] b);
        vword = {vword[23:0], b};
        if (vstate < 3) begin
            vstate = prefix_step(vstate, b);
        end else if (vstate == 3) begin
            vstate = (b == 8'hB3) ? 10 : (b == 8'hB8) ? 20 : (b == 8'h00) ? 30 : 0;
        end else if (vstate == 10 || vstate == 23 || vstate == 33) begin
            ev_kind_q.push_back(vstate / 10 - 1);
            ev_tc_q.push_back(vword[31:7]);
            // First two picture payload bytes sit in bits 31 to 16
            ev_tr_q.push_back(vword[31:22]);
            vstate = 0;
        end else begin
            vstate++;
        end
    endtask

    task automatic model_audio(input logic [7:0] b);
        aword = {aword[31:0], b};
        if (astate < 3) begin
            astate = prefix_step(astate, b);
        end else if (astate == 3) begin
            astate = (b == 8'hBA) ? 40 : 0;
        end else if (astate == 44) begin
            scr_hist.push_back({aword[35:33], aword[31:24], aword[23:17],
                                aword[15:8], aword[7:1]});
            astate = 0;
        end else begin
            astate++;
        end
    endtask

    task automatic push_byte(input logic [7:0] d, input bit a);
        data_q.push_back(d);
        audio_q.push_back(a);
        if (a)
            model_audio(d);
        else
            model_video(d);
    endtask

    task automatic push_header(input logic [7:0] code, input int n, input bit a);
        push_byte(8'h00, a);
        push_byte(8'h00, a);
        push_byte(8'h01, a);
        push_byte(code, a);
        repeat (n) push_byte(8'(rnd(256)), a);
    endtask

    task automatic gen_item();
        int t;
        bit a;
        t = rnd(8);
        a = rnd(2) == 1;
        case (t)
            0: push_byte(8'(rnd(256)), a);
            1: push_header(8'hB3, 1, 1'b0);
            2: push_header(8'hB8, 4, 1'b0);
            3: push_header(8'h00, 4, 1'b0);
            4: push_header(8'hBA, 5, 1'b1);
            5: begin
                // Broken start codes
                push_byte(8'h00, a);
                push_byte(8'h00, a);
                push_byte(rnd(2) == 1 ? 8'h02 : 8'h01, a);
                push_byte(8'hC5, a);
            end
            6: begin
                repeat (1 + rnd(3)) push_byte(8'h00, 1'b0);
                push_header(rnd(2) == 1 ? 8'hB8 : 8'h00, 4, 1'b0);
            end
            default: push_header(8'hBA, 5, 1'b0);
        endcase
    endtask

    // Called 1 ns after a rising edge and returns at the same point
    task automatic send_byte(input logic [7:0] d, input bit a);
        bit accepted;
        accepted = 0;
        in_data  = d;
        in_audio = a;
        in_valid = 1'b1;
        while (!accepted) begin
            #1;
            accepted = in_ready;
            if (!in_ready) begin
                ready_dropped = 1;
                hold_vsync    = 0;
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        repeat (rnd(3)) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_pending();
        while (sent < data_q.size()) begin
            send_byte(data_q[sent], audio_q[sent]);
            sent++;
        end
    endtask

    task automatic read_reg(input logic [3:0] a, output logic [15:0] d);
        reg_addr = a;
        reg_read = 1'b1;
        #1;
        d = reg_rdata;
        @(posedge clk);
        #1;
        reg_read = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] a, input logic [15:0] d);
        reg_addr  = a;
        reg_wdata = d;
        reg_write = 1'b1;
        @(posedge clk);
        #1;
        reg_write = 1'b0;
    endtask

    task automatic vsync_pulse(output bit prev);
        prev     = tb_phase;
        tb_phase = !tb_phase;
        vsync    = 1'b1;
        repeat (20) begin
            @(posedge clk);
            #1;
        end
        vsync = 1'b0;
        repeat (20) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_release(input bit prev);
        logic [15:0] v;
        logic [15:0] hi;
        logic [15:0] lo;
        logic [2:0]  exp_bits;
        int          k;
        read_reg(4'd1, v);
        if (v[2:0] != 3'b000) begin
            assert (prev) else report("video event released on the first vsync of a pair");
            assert (ev_kind_q.size() > 0) else report("video event released, none expected");
            if (ev_kind_q.size() > 0) begin
                k = ev_kind_q.pop_front();
                exp_bits = 3'b001 << k;
                assert (v[2:0] == exp_bits) else report($sformatf(
                    "ISR video bits %b, expected %b", v[2:0], exp_bits));
                if (k == 1) begin
                    read_reg(4'd2, hi);
                    read_reg(4'd3, lo);
                    assert ({hi[8:0], lo} == ev_tc_q[0]) else report($sformatf(
                        "timecode %h, expected %h", {hi[8:0], lo}, ev_tc_q[0]));
                end
                if (k == 2) begin
                    read_reg(4'd4, lo);
                    assert (lo == {6'd0, ev_tr_q[0]}) else report($sformatf(
                        "TMPREF %h, expected %h", lo, ev_tr_q[0]));
                end
                void'(ev_tc_q.pop_front());
                void'(ev_tr_q.pop_front());
            end
        end
    endtask

    task automatic check_packs();
        logic [15:0] c1;
        logic [15:0] c2;
        logic [15:0] hi;
        logic [15:0] lo;
        read_reg(4'd7, c1);
        read_reg(4'd5, hi);
        read_reg(4'd6, lo);
        read_reg(4'd7, c2);
        assert (int'(c2) <= scr_hist.size()) else report("PACK_COUNT above model count");
        if (c1 == c2 && c1 != 0 && int'(c1) <= scr_hist.size()) begin
            assert ({hi, lo} == scr_hist[c1 - 1][32:1]) else report($sformatf(
                "SCR %h, expected %h", {hi, lo}, scr_hist[c1 - 1][32:1]));
        end
    endtask

    initial begin
        logic [15:0] v;
        logic [3:0]  mask;
        bit          prev;
        reset     = 1;
        in_data   = '0;
        in_audio  = 0;
        in_valid  = 0;
        vsync     = 0;
        reg_addr  = '0;
        reg_write = 0;
        reg_read  = 0;
        reg_wdata = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 0;

        assert (in_ready && !irq) else report("in_ready or irq wrong after reset");
        for (int a = 0; a < 16; a++) begin
            read_reg(4'(a), v);
            assert (v == 16'd0) else report($sformatf("register %0d reads %h", a, v));
        end

        // Burst of sequence headers first with vsync held low
        repeat (12) push_header(8'hB3, 1, 1'b0);
        repeat (150) gen_item();
        push_byte(8'hFF, 1'b0);
        push_byte(8'hFF, 1'b1);
        limit = cycles + 4 * (data_q.size() + 8 * 16 + 40 * (ev_kind_q.size() + 8));

        fork
            begin
                send_pending();
                stream_done = 1;
            end
            while (!stream_done || ev_kind_q.size() != 0) begin
                if (hold_vsync) begin
                    @(posedge clk);
                    #1;
                end else begin
                    vsync_pulse(prev);
                    check_release(prev);
                    check_packs();
                end
            end
        join
        assert (ready_dropped) else report("in_ready never dropped during the burst");
        check_packs();
        read_reg(4'd7, v);
        assert (int'(v) == scr_hist.size()) else report("final pack count mismatch");

        // Interrupt enable masks against a pack plus a sequence event
        for (int i = 0; i < 8; i++) begin
            mask = 4'(rnd(16));
            write_reg(4'd0, {12'd0, mask});
            read_reg(4'd1, v);
            push_header(8'hBA, 5, 1'b1);
            push_header(8'hB3, 1, 1'b0);
            send_pending();
            repeat (4) begin
                @(posedge clk);
                #1;
            end
            prev = 0;
            while (!prev) vsync_pulse(prev);
            assert (irq == |(4'b1001 & mask)) else report($sformatf(
                "irq %b with mask %b", irq, mask));
            read_reg(4'd1, v);
            assert (v == 16'h0009) else report($sformatf("ISR %h, expected 0009", v));
            ev_kind_q.delete();
            ev_tc_q.delete();
            ev_tr_q.delete();
            repeat (3) begin
                @(posedge clk);
                #1;
            end
            assert (!irq) else report("irq still high after ISR was cleared");
            read_reg(4'd1, v);
            assert (v == 16'd0) else report($sformatf("ISR %h after clear", v));
            check_packs();
        end

        $display("Closing count: %0d errors", errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hdl
hdl/mpeg_stream_pkg.sv
hdl/mpeg_regs_pkg.sv
hdl/video_header_parser.sv
hdl/audio_pack_parser.sv
hdl/video_event_fifo.sv
hdl/mpeg_host_regs.sv
hdl/mpeg_decoder_top.sv
tb/tb_mpeg_decoder.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_mpeg_decoder -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

# Exit status follows the search for the pass message
echo "$out" | grep -q "TB PASSED"
